// File: fdiv_top.f
fdiv_pkg.sv
mant_divider.sv
exp_sign_unit.sv
div_normalizer.sv
fdiv_top.sv
tb_fdiv.sv

// File: run_sim.sh
#!/bin/sh
# Builds the divider testbench with Verilator and runs it
# The exit status is the simulator's, nonzero when a check fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fdiv -f fdiv_top.f -o sim_fdiv
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_fdiv
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished cleanly"
exit 0

// File: tb_fdiv.sv
`timescale 1ns/1ps

module tb_fdiv;
	import fdiv_pkg::*;

	// ================================================
	// Constants and bookkeeping
	// ================================================

	// Edges from the accepting edge to the one that raises result_valid
	localparam int unsigned RESULT_LAT = 51;
	localparam int N_RANDOM = 200;

	// One division in flight together with the edge that accepted its start
	typedef struct packed {
		fp32_t a;
		fp32_t b;
		fp32_t expected;
		logic [31:0] acc_edge;
	} pending_t;

	logic clk_div;
	logic rst_n;
	logic start;
	fp32_t a;
	fp32_t b;
	logic busy;
	fp32_t result;
	logic result_valid;

	pending_t case_q[$];
	pending_t pend_q[$];
	int unsigned edge_cnt = 0;
	int unsigned cycle_limit = 0;

	fdiv_top dut0 (
		.clk_div      (clk_div),
		.rst_n        (rst_n),
		.start        (start),
		.a            (a),
		.b            (b),
		.busy         (busy),
		.result       (result),
		.result_valid (result_valid)
	);

	initial begin
		clk_div = 1'b0;
		forever #4 clk_div = ~clk_div;
	end

	// ================================================
	// Reference model
	// ================================================

	// Truncating binary32 divide that flushes subnormals and underflow to zero
	function automatic fp32_t ref_div(fp32_t x, fp32_t y);
		logic [7:0] ex;
		logic [7:0] ey;
		logic x_nan;
		logic y_nan;
		logic x_inf;
		logic y_inf;
		logic x_zero;
		logic y_zero;
		logic s;
		logic [63:0] q;
		logic [22:0] frac;
		int e;
		int be;
		ex = x[30:23];
		ey = y[30:23];
		s = x[31] ^ y[31];
		x_nan = (ex == 8'hFF) && (x[22:0] != 23'd0);
		y_nan = (ey == 8'hFF) && (y[22:0] != 23'd0);
		x_inf = (ex == 8'hFF) && (x[22:0] == 23'd0);
		y_inf = (ey == 8'hFF) && (y[22:0] == 23'd0);
		// Subnormals read as zero
		x_zero = (ex == 8'd0);
		y_zero = (ey == 8'd0);
		if (x_nan || y_nan || (x_zero && y_zero) || (x_inf && y_inf))
			return 32'h7FC00000;
		if (x_inf || y_zero)
			return {s, 8'hFF, 23'd0};
		if (x_zero || y_inf)
			return {s, 31'd0};
		// Significand ratio scaled by 2^25 with plain integer division
		q = ({40'd0, 1'b1, x[22:0]} << 25) / {40'd0, 1'b1, y[22:0]};
		e = int'(ex) - int'(ey);
		if (q[25]) begin
			frac = q[24:2];
			be = e + 127;
		end else begin
			frac = q[23:1];
			be = e + 126;
		end
		if (be <= 0)
			return {s, 31'd0};
		if (be >= 255)
			return {s, 8'hFF, 23'd0};
		return {s, be[7:0], frac};
	endfunction

	// Exponents stay moderate except for every eighth word, which is fully random
	function automatic fp32_t rand_operand(int idx);
		logic [31:0] r;
		r = $urandom;
		if (idx % 8 == 7)
			return r;
		return {r[31], 8'd64 + {1'b0, r[30:24]}, r[22:0]};
	endfunction

	// ================================================
	// Checks
	// ================================================

	task automatic check_result(input fp32_t op_a, input fp32_t op_b, input fp32_t got,
			input fp32_t expected);
		if (got !== expected) begin
			$display("Error at %0t ns: a=%h b=%h result %h expected %h",
				$time, op_a, op_b, got, expected);
			$display("TESTS FAILED");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic check_latency(input int unsigned got_edge, input int unsigned exp_edge);
		if (got_edge != exp_edge) begin
			$display("result_valid came at edge %0d, it should have come at edge %0d",
				got_edge, exp_edge);
			$display("TESTS FAILED");
			$fatal(1, "wrong result latency");
		end
	endtask

	// Edge counter doubles as the watchdog
	always @(posedge clk_div) begin
		edge_cnt = edge_cnt + 1;
		if (cycle_limit != 0 && edge_cnt > cycle_limit) begin
			$display("TESTS FAILED");
			$fatal(1, "timeout, the run went past %0d cycles", cycle_limit);
		end
	end

	// Outputs only move on rising edges, so the falling edge sees them settled
	always @(negedge clk_div) begin
		if (rst_n) begin
			if (pend_q.size() != 0 && !busy && edge_cnt >= pend_q[0].acc_edge &&
					edge_cnt <= pend_q[0].acc_edge + RESULT_LAT) begin
				$display("TESTS FAILED");
				$fatal(1, "busy went low while a division was running");
			end
			if (result_valid) begin
				if (pend_q.size() == 0) begin
					$display("TESTS FAILED");
					$fatal(1, "result_valid pulsed with no division pending");
				end
				check_latency(edge_cnt, pend_q[0].acc_edge + RESULT_LAT);
				check_result(pend_q[0].a, pend_q[0].b, result, pend_q[0].expected);
				void'(pend_q.pop_front());
			end
		end
	end

	// ================================================
	// Stimulus
	// ================================================

	function automatic void add_case(fp32_t op_a, fp32_t op_b, fp32_t expected);
		pending_t p;
		p.a = op_a;
		p.b = op_b;
		p.expected = expected;
		p.acc_edge = '0;
		case_q.push_back(p);
	endfunction

	function automatic void add_ref_case(fp32_t op_a, fp32_t op_b);
		add_case(op_a, op_b, ref_div(op_a, op_b));
	endfunction

	// Runs from 1 ns after a rising edge to 1 ns after the accepting edge
	task automatic issue(input fp32_t op_a, input fp32_t op_b, input fp32_t expected);
		pending_t p;
		while (busy) begin
			@(posedge clk_div);
			#1;
		end
		start = 1'b1;
		a = op_a;
		b = op_b;
		p.a = op_a;
		p.b = op_b;
		p.expected = expected;
		// busy is low now, so the coming edge takes the start
		p.acc_edge = edge_cnt + 1;
		pend_q.push_back(p);
		@(posedge clk_div);
		#1;
		start = 1'b0;
	endtask

	// Starts with other operands while busy must leave no trace
	task automatic poke_while_busy();
		for (int i = 0; i < 3; i++) begin
			if (!busy) begin
				$display("TESTS FAILED");
				$fatal(1, "busy was low right after a start was accepted");
			end
			start = 1'b1;
			a = 32'h3F800000 + i;
			b = 32'h40E00000;
			@(posedge clk_div);
			#1;
		end
		start = 1'b0;
	endtask

	initial begin
		fp32_t ra;
		fp32_t rb;
		rst_n = 1'b0;
		start = 1'b0;
		a = '0;
		b = '0;
		void'($urandom(95));

		// Exact quotients and sign
		add_case(32'h40C00000, 32'h40400000, 32'h40000000);
		add_case(32'h3F800000, 32'h40800000, 32'h3E800000);
		add_case(32'hC0F00000, 32'h40200000, 32'hC0400000);
		add_case(32'h40C00000, 32'hC0400000, 32'hC0000000);
		// Both normalization branches with truncation
		add_ref_case(32'h3F800000, 32'h40400000);
		add_ref_case(32'h40000000, 32'h40400000);
		add_ref_case(32'h3FC00000, 32'h3FA00000);
		add_ref_case(32'h41200000, 32'h40400000);
		add_ref_case(32'h3FFFFFFF, 32'h3F800001);
		// Special classes in priority order
		add_case(32'h40000000, 32'h00000000, 32'h7F800000);
		add_case(32'hC0000000, 32'h00000000, 32'hFF800000);
		add_case(32'h00000000, 32'h80000000, QNAN);
		add_case(32'h7F800000, 32'hFF800000, QNAN);
		add_case(32'hFF800000, 32'h40000000, 32'hFF800000);
		add_case(32'h40000000, 32'h7F800000, 32'h00000000);
		add_case(32'h80000000, 32'h40000000, 32'h80000000);
		add_case(32'h7FC00001, 32'h40000000, QNAN);
		add_case(32'h40000000, 32'hFFA00000, QNAN);
		add_case(32'h7F800001, 32'h00000000, QNAN);
		add_case(32'h00000001, 32'h40000000, 32'h00000000);
		add_case(32'h40000000, 32'h00400000, 32'h7F800000);
		add_case(32'h00400000, 32'h80000001, QNAN);
		// Exponent overflow and underflow
		add_case(32'h7F7FFFFF, 32'h00800000, 32'h7F800000);
		add_case(32'hFF7FFFFF, 32'h00800000, 32'hFF800000);
		add_case(32'h00800000, 32'h7F7FFFFF, 32'h00000000);
		add_case(32'h80800000, 32'h7F7FFFFF, 32'h80000000);
		add_case(32'h7F000000, 32'h3F000000, 32'h7F800000);

		cycle_limit = (case_q.size() + N_RANDOM) * 60 + 200;

		repeat (10) @(posedge clk_div);
		#1;
		rst_n = 1'b1;

		foreach (case_q[i]) begin
			issue(case_q[i].a, case_q[i].b, case_q[i].expected);
			// The first division also carries the ignored starts
			if (i == 0)
				poke_while_busy();
		end

		// Back to back as soon as busy falls
		for (int i = 0; i < N_RANDOM; i++) begin
			ra = rand_operand(i);
			rb = rand_operand(i + 3);
			issue(ra, rb, ref_div(ra, rb));
		end

		while (pend_q.size() != 0 || busy)
			@(posedge clk_div);
		// A stray result strobe after the last division shows up in this window
		repeat (RESULT_LAT + 2) @(posedge clk_div);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: fdiv_top.sv
`timescale 1ns/1ps

module fdiv_top (
	input  logic            clk_div,
	input  logic            rst_n,
	input  logic            start,
	input  fdiv_pkg::fp32_t a,
	input  fdiv_pkg::fp32_t b,
	output logic            busy,
	output fdiv_pkg::fp32_t result,
	output logic            result_valid
);
	import fdiv_pkg::*;

	// Accepted start, seen by both front units in the same cycle
	logic go;
	// Sign, exponent and class from the exponent unit
	exp_info_t info;
	// Quotient and its strobe from the mantissa divider
	quot_res_t qres;
	logic q_done;

	// A start during a running division is dropped, there is no queue
	assign go = start & ~busy;

	// ================================================
	// Busy flag
	// ================================================

	// Set by the accepted start, cleared once the result strobe has been seen
	always_ff @(posedge clk_div or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (go) begin
			busy <= 1'b1;
		end else if (result_valid) begin
			busy <= 1'b0;
		end
	end

	// ================================================
	// Datapath units
	// ================================================

	// Significand division, the long path of about fifty cycles
	mant_divider u_mant_divider (
		.clk_div (clk_div),
		.rst_n   (rst_n),
		.go      (go),
		.a       (a),
		.b       (b),
		.qres    (qres),
		.q_done  (q_done)
	);

	// Sign, exponent and class are ready one edge after go
	exp_sign_unit u_exp_sign_unit (
		.clk_div (clk_div),
		.rst_n   (rst_n),
		.go      (go),
		.a       (a),
		.b       (b),
		.info    (info)
	);

	div_normalizer u_div_normalizer (
		.clk_div      (clk_div),
		.rst_n        (rst_n),
		.q_done       (q_done),
		.qres         (qres),
		.info         (info),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

// File: div_normalizer.sv
`timescale 1ns/1ps

module div_normalizer (
	input  logic                clk_div,
	input  logic                rst_n,
	input  logic                q_done,
	input  fdiv_pkg::quot_res_t qres,
	input  fdiv_pkg::exp_info_t info,
	output fdiv_pkg::fp32_t     result,
	output logic                result_valid
);
	import fdiv_pkg::*;

	// Leading bit of the quotient tells which normalization applies
	logic top_bit;
	// Truncated fraction after normalization
	logic [FRAC_W-1:0] frac;
	// Biased exponent before the range checks, signed so underflow shows
	exp_t biased;

	fp_fields_t res_f;
	fp32_t res_next;

	// ================================================
	// Normalization
	// ================================================

	// Quotient is ratio times 2^25 and the ratio lies between one half and two
	always_comb begin
		top_bit = qres.quot[QUOT_W-1];
		if (top_bit) begin
			// Ratio is one or more, the hidden one sits at bit 25
			frac = qres.quot[QUOT_W-2:2];
			biased = info.exp_diff + exp_t'(EXP_BIAS);
		end else begin
			// Ratio below one, hidden one at bit 24 and one less in the exponent
			frac = qres.quot[QUOT_W-3:1];
			biased = info.exp_diff + exp_t'(EXP_BIAS - 1);
		end
	end

	// ================================================
	// Range checks and special classes
	// ================================================

	always_comb begin
		res_f.sign = info.sign;
		res_f.exp = biased[7:0];
		res_f.frac = frac;
		case (info.cls)
			ZERO: begin
				res_f.exp = 8'd0;
				res_f.frac = '0;
			end
			INF: begin
				res_f.exp = EXP_ALL_ONES;
				res_f.frac = '0;
			end
			default: begin
				// Underflow flushes to a signed zero, no subnormal results
				if (biased <= exp_t'(0)) begin
					res_f.exp = 8'd0;
					res_f.frac = '0;
				end else if (biased >= exp_t'(EXP_SAT)) begin
					// overflow saturates to infinity
					res_f.exp = EXP_ALL_ONES;
					res_f.frac = '0;
				end
			end
		endcase
		// NaN ignores the sign and always comes out canonical
		if (info.cls == NAN) begin
			res_next = QNAN;
		end else begin
			res_next = fp32_t'(res_f);
		end
	end

	// ================================================
	// Output register
	// ================================================

	// Sampled on the edge that ends the q_done cycle, held until the next one
	always_ff @(posedge clk_div or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= q_done;
			if (q_done) begin
				result <= res_next;
			end
		end
	end

endmodule

// File: exp_sign_unit.sv
`timescale 1ns/1ps

module exp_sign_unit (
	input  logic                clk_div,
	input  logic                rst_n,
	input  logic                go,
	input  fdiv_pkg::fp32_t     a,
	input  fdiv_pkg::fp32_t     b,
	output fdiv_pkg::exp_info_t info
);
	import fdiv_pkg::*;

	fp_fields_t fa;
	fp_fields_t fb;

	// Operand classes
	logic a_nan;
	logic b_nan;
	logic a_inf;
	logic b_inf;
	logic a_zero;
	logic b_zero;

	res_class_t cls_next;
	exp_t diff_next;

	assign fa = a;
	assign fb = b;

	// ================================================
	// Operand classification
	// ================================================

	// All-ones exponent is infinity with a zero fraction, NaN otherwise
	assign a_nan = (fa.exp == EXP_ALL_ONES) && (fa.frac != '0);
	assign b_nan = (fb.exp == EXP_ALL_ONES) && (fb.frac != '0);
	assign a_inf = (fa.exp == EXP_ALL_ONES) && (fa.frac == '0);
	assign b_inf = (fb.exp == EXP_ALL_ONES) && (fb.frac == '0);

	// Subnormals count as zero, only the exponent field is looked at
	assign a_zero = (fa.exp == 8'd0);
	assign b_zero = (fb.exp == 8'd0);

	// Class of the quotient, first match wins
	always_comb begin
		if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
			// Invalid operations all collapse into the quiet NaN
			cls_next = NAN;
		end else if (a_inf || b_zero) begin
			cls_next = INF;
		end else if (a_zero || b_inf) begin
			cls_next = ZERO;
		end else begin
			cls_next = NORMAL;
		end
	end

	// Unbiased difference, the bias cancels out and is added back later
	assign diff_next = exp_t'({2'b00, fa.exp}) - exp_t'({2'b00, fb.exp});

	// ================================================
	// Output register
	// ================================================

	// info is loaded at the accepting edge and holds until the next go
	always_ff @(posedge clk_div or negedge rst_n) begin
		if (!rst_n) begin
			info <= '0;
		end else if (go) begin
			// Sign of the result is the XOR of the operand signs for every class
			info.sign <= fa.sign ^ fb.sign;
			info.exp_diff <= diff_next;
			info.cls <= cls_next;
		end
	end

endmodule

// File: mant_divider.sv
`timescale 1ns/1ps

module mant_divider (
	input  logic                clk_div,
	input  logic                rst_n,
	input  logic                go,
	input  fdiv_pkg::fp32_t     a,
	input  fdiv_pkg::fp32_t     b,
	output fdiv_pkg::quot_res_t qres,
	output logic                q_done
);
	import fdiv_pkg::*;

	// Field views of the two operands
	fp_fields_t fa;
	fp_fields_t fb;

	// Significands with the hidden bit restored
	mant_t mant_a;
	mant_t mant_b;

	div_state_t state;
	cnt_t cnt;

	// Dividend bits leave at the top while quotient bits enter at the bottom,
	// so after DIV_ITER shifts the register holds the whole quotient
	logic [DIV_ITER-1:0] shreg;

	// Partial remainder stays below the divisor between steps
	mant_t rem;
	// Divisor significand held for the whole division
	mant_t divisor;

	// One bit wider than the remainder to hold the shifted value
	logic [MANT_W:0] trial;
	logic [MANT_W:0] diff;
	logic q_bit;

	assign fa = a;
	assign fb = b;

	// A zero exponent field means zero or subnormal, so no hidden one
	// The quotient for such operands is thrown away by the normalizer
	assign mant_a = {(fa.exp != 8'd0), fa.frac};
	assign mant_b = {(fb.exp != 8'd0), fb.frac};

	// ================================================
	// Restoring step
	// ================================================

	// Bring down the next dividend bit next to the remainder
	assign trial = {rem, shreg[DIV_ITER-1]};
	// Quotient bit is one when the divisor fits into the trial value
	assign q_bit = (trial >= {1'b0, divisor});
	assign diff = trial - {1'b0, divisor};

	// ================================================
	// Control
	// ================================================

	// go is sampled at edge 0, the shifts run on edges 1 to 49 and q_done rises at edge 50
	always_ff @(posedge clk_div or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			cnt <= '0;
			q_done <= 1'b0;
		end else begin
			// q_done is a strobe and drops unless set below
			q_done <= 1'b0;
			case (state)
				IDLE: begin
					if (go) begin
						state <= RUN;
						cnt <= cnt_t'(DIV_ITER);
					end
				end
				RUN: begin
					cnt <= cnt - cnt_t'(1);
					// Last shift happens on this edge
					if (cnt == cnt_t'(1)) begin
						state <= FINISH;
					end
				end
				FINISH: begin
					q_done <= 1'b1;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ================================================
	// Datapath
	// ================================================

	always_ff @(posedge clk_div) begin
		if (go && state == IDLE) begin
			// Dividend is the significand of a scaled by 2^25
			shreg <= {mant_a, {(DIV_ITER - MANT_W){1'b0}}};
			rem <= '0;
			divisor <= mant_b;
		end else if (state == RUN) begin
			shreg <= {shreg[DIV_ITER-2:0], q_bit};
			// Keep the difference when the divisor fitted, else restore
			rem <= q_bit ? diff[MANT_W-1:0] : trial[MANT_W-1:0];
		end
	end

	// The upper quotient bits are always zero since the ratio is below two
	always_ff @(posedge clk_div) begin
		if (state == FINISH) begin
			qres.quot <= shreg[QUOT_W-1:0];
		end
	end

endmodule

// File: fdiv_pkg.sv
package fdiv_pkg;

	// ================================================
	// Widths and constants
	// ================================================

	// Significand with the hidden one in front of the 23 fraction bits
	localparam int MANT_W = 24;
	localparam int FRAC_W = 23;
	// Quotient keeps two bits above the binary point of the significand ratio
	localparam int QUOT_W = 26;
	// Room for exponent differences from -254 to +254 and for adding the bias
	localparam int EXP_W = 10;
	// Dividend bits pushed through the divider, the significand plus 25 zeros
	localparam int DIV_ITER = 49;
	// Wide enough to hold DIV_ITER
	localparam int CNT_W = 6;
	localparam int EXP_BIAS = 127;
	// First biased exponent that no longer fits a finite number
	localparam int EXP_SAT = 255;
	localparam logic [7:0] EXP_ALL_ONES = 8'hFF;

	// ================================================
	// Vector types
	// ================================================

	typedef logic [31:0] fp32_t;
	typedef logic [MANT_W-1:0] mant_t;
	typedef logic [QUOT_W-1:0] quot_t;
	typedef logic signed [EXP_W-1:0] exp_t;
	typedef logic [CNT_W-1:0] cnt_t;
	typedef logic [1:0] res_class_t;

	// Canonical quiet NaN used for every invalid result
	localparam fp32_t QNAN = 32'h7FC00000;

	// Result classes as seen by the normalizer
	localparam res_class_t NORMAL = 2'd0;
	localparam res_class_t ZERO = 2'd1;
	localparam res_class_t INF = 2'd2;
	localparam res_class_t NAN = 2'd3;

	// ================================================
	// Structs and state machine
	// ================================================

	// Field view of a binary32 word, same bit layout as fp32_t
	typedef struct packed {
		logic sign;
		logic [7:0] exp;
		logic [FRAC_W-1:0] frac;
	} fp_fields_t;

	// Everything the normalizer needs apart from the quotient
	typedef struct packed {
		logic sign;
		exp_t exp_diff;
		res_class_t cls;
	} exp_info_t;

	typedef struct packed {
		quot_t quot;
	} quot_res_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FINISH
	} div_state_t;

endpackage
